// File: verilog.f
logic/sys_master_pkg.sv
logic/wb_link_if.sv
logic/reset_sync.sv
logic/dwidth_downsizer.sv
logic/wb_bus_master.sv
logic/sys_master.sv
tb/wb_mem_model.sv
tb/tb_sys_master.sv

// File: tb/tb_sys_master.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sys_master
    import sys_master_pkg::*;
();

    localparam int unsigned SEED        = 32'h92468bfa;
    localparam int          ACK_TIMEOUT = 64;   // Cycles allowed per host transfer

    logic        main_clk, rst, locked, soc_rst;
    logic        host_cyc, host_stb, host_we, host_ack;
    addr_t       host_adr;
    host_data_t  host_dat, host_dat_o;
    host_sel_t   host_sel;
    logic        m_cyc, m_stb, m_we, m_ack;
    addr_t       m_adr;
    bus_data_t   m_dat_o, m_dat_i;
    bus_sel_t    m_sel;
    int unsigned beat_count;

    host_data_t  ref_mem [int unsigned];   // Host word index to expected contents
    int          check_count, error_count, timeout_count;

    sys_master u_dut (
        .main_clk_i (main_clk), .rst_i (rst), .locked_i (locked), .soc_rst_o (soc_rst),
        .host_cyc_i (host_cyc), .host_stb_i (host_stb), .host_we_i (host_we),
        .host_adr_i (host_adr), .host_dat_i (host_dat), .host_sel_i (host_sel),
        .host_dat_o (host_dat_o), .host_ack_o (host_ack),
        .m_cyc_o (m_cyc), .m_stb_o (m_stb), .m_we_o (m_we), .m_adr_o (m_adr),
        .m_dat_o (m_dat_o), .m_sel_o (m_sel), .m_dat_i (m_dat_i), .m_ack_i (m_ack)
    );

    wb_mem_model u_mem (
        .clk_i (main_clk), .rst_i (rst), .cyc_i (m_cyc), .stb_i (m_stb), .we_i (m_we),
        .adr_i (m_adr), .dat_i (m_dat_o), .sel_i (m_sel), .dat_o (m_dat_i), .ack_o (m_ack),
        .beat_count_o (beat_count)
    );

    always #4 main_clk = ~main_clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // Reset must hold for exactly RESET_SYNC_STAGES locked edges
    task automatic check_release();
        for (int i = 1; i <= RESET_SYNC_STAGES; i++) begin
            @(negedge main_clk);
            check_value("reset release", (i < RESET_SYNC_STAGES), soc_rst);
            check_value("bus idle in reset", 0, m_cyc);
            check_value("bus strobe in reset", 0, m_stb);
            check_value("host ack in reset", 0, host_ack);
        end
    endtask

    function automatic host_sel_t random_sel();
        host_sel_t sel;
        sel = host_sel_t'($urandom);
        case ($urandom_range(3, 0))
            0: sel = '0;
            1: sel[7:4] = '0;   // Low half only
            2: sel[3:0] = '0;
            default: ;
        endcase
        return sel;
    endfunction

    // One host transfer, checked against the reference model; called on a falling edge
    task automatic run_transfer(input logic we, input addr_t adr, input host_data_t dat,
                                input host_sel_t sel);
        int unsigned word;
        int unsigned beats_before;
        int unsigned beats_exp;
        int          cycles;
        host_data_t  expected;
        word         = adr[7:3];
        beats_before = beat_count;
        beats_exp    = (sel[3:0] != 0) + (sel[7:4] != 0);
        if (sel == '0) beats_exp = 1;   // Empty sel still costs the low beat
        host_cyc = 1'b1;
        host_stb = 1'b1;
        host_we  = we;
        host_adr = adr;
        host_dat = dat;
        host_sel = sel;
        cycles   = 0;
        do begin
            @(negedge main_clk);
            cycles++;
        end while (!host_ack && cycles < ACK_TIMEOUT);
        if (!host_ack) begin
            $display("No host ack arrived within %0d cycles for address %h", ACK_TIMEOUT, adr);
            timeout_count++;
        end else begin
            check_value("beat count", beats_exp, beat_count - beats_before);
            expected = ref_mem.exists(word) ? ref_mem[word] : '0;
            if (we) begin
                for (int b = 0; b < HOST_SEL_WIDTH; b++) begin
                    if (sel[b]) expected[8*b +: 8] = dat[8*b +: 8];
                end
                ref_mem[word] = expected;
            end else begin
                if (sel[3:0] == '0 && sel != '0) expected[31:0] = '0;   // Skipped low half
                if (sel[7:4] == '0) expected[63:32] = '0;
                check_value("read data", expected, host_dat_o);
            end
        end
        host_cyc = 1'b0;
        host_stb = 1'b0;
        @(negedge main_clk);
    endtask

    task automatic run_random(input int count);
        addr_t      adr;
        host_data_t dat;
        logic       we;
        repeat (count) begin
            adr = $urandom_range(255, 0);
            dat = {$urandom, $urandom};
            we  = $urandom_range(1, 0);
            run_transfer(we, adr, dat, random_sel());
            if (we && $urandom_range(1, 0)) run_transfer(1'b0, adr, '0, 8'hff);   // Readback
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        main_clk      = 1'b0;
        rst           = 1'b1;
        locked        = 1'b0;
        host_cyc      = 1'b0;
        host_stb      = 1'b0;
        host_we       = 1'b0;
        host_adr      = '0;
        host_dat      = '0;
        host_sel      = '0;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        repeat (5) @(negedge main_clk);
        rst    = 1'b0;
        locked = 1'b1;
        check_release();

        // Known contents for the whole window
        for (int w = 0; w < 32; w++) begin
            run_transfer(1'b1, addr_t'(w * 8), {$urandom, $urandom}, 8'hff);
        end
        run_random(200);

        // Lock loss while idle
        locked = 1'b0;
        repeat (3) begin
            @(negedge main_clk);
            check_value("lock loss reset", 1, soc_rst);
        end
        locked = 1'b1;
        check_release();
        run_random(100);

        $display("Checks: %0d  errors: %0d  timeouts: %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_sys_master

`default_nettype wire

// File: tb/wb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

// Wishbone classic slave memory over a 256-byte window
module wb_mem_model
    import sys_master_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  addr_t       adr_i,
    input  bus_data_t   dat_i,
    input  bus_sel_t    sel_i,
    output bus_data_t   dat_o,
    output logic        ack_o,
    output int unsigned beat_count_o   // Acknowledged beats since reset
);

    bus_data_t   mem [0:63];   // Word addressed
    logic [5:0]  word_idx;
    logic        busy;         // Wait states drawn for the current beat
    int unsigned wait_cnt;

    assign word_idx = adr_i[7:2];

    // Byte lanes of a write that the select lets through
    function automatic bus_data_t merge_bytes(bus_data_t old_word, bus_data_t new_word,
                                              bus_sel_t sel);
        bus_data_t merged;
        merged = old_word;
        for (int b = 0; b < BUS_SEL_WIDTH; b++) begin
            if (sel[b]) merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    initial begin
        ack_o        = 1'b0;
        dat_o        = '0;
        busy         = 1'b0;
        wait_cnt     = 0;
        beat_count_o = 0;
    end

    // Responses change on the falling edge
    always @(negedge clk_i) begin
        if (rst_i) begin
            ack_o        <= 1'b0;
            busy         <= 1'b0;
            wait_cnt     <= 0;
            beat_count_o <= 0;
        end else begin
            ack_o <= 1'b0;   // Single cycle ack
            if (cyc_i && stb_i && !ack_o) begin
                if (!busy) begin
                    busy     <= 1'b1;
                    wait_cnt <= $urandom_range(3, 0);
                end else if (wait_cnt != 0) begin
                    wait_cnt <= wait_cnt - 1;
                end else begin
                    busy         <= 1'b0;
                    ack_o        <= 1'b1;
                    beat_count_o <= beat_count_o + 1;
                    dat_o        <= mem[word_idx];
                    if (we_i) mem[word_idx] <= merge_bytes(mem[word_idx], dat_i, sel_i);
                end
            end
        end
    end

endmodule : wb_mem_model

`default_nettype wire

// File: logic/sys_master.sv
`timescale 1ns/10ps
`default_nettype none

module sys_master
    import sys_master_pkg::*;
(
    // Clock and reset
    input  logic       main_clk_i,
    input  logic       rst_i,
    input  logic       locked_i,    // From the clock generator
    output logic       soc_rst_o,   // Reset for the main domain

    // 64-bit host port
    input  logic       host_cyc_i,
    input  logic       host_stb_i,
    input  logic       host_we_i,
    input  addr_t      host_adr_i,
    input  host_data_t host_dat_i,
    input  host_sel_t  host_sel_i,
    output host_data_t host_dat_o,
    output logic       host_ack_o,

    // 32-bit system bus
    output logic       m_cyc_o,
    output logic       m_stb_o,
    output logic       m_we_o,
    output addr_t      m_adr_o,
    output bus_data_t  m_dat_o,
    output bus_sel_t   m_sel_o,
    input  bus_data_t  m_dat_i,
    input  logic       m_ack_i
);

    ////////////////////////////////////////////////////////////
    // Reset generation
    ////////////////////////////////////////////////////////////

    reset_sync u_reset_sync (
        .main_clk_i ( main_clk_i ),
        .rst_i      ( rst_i      ),
        .locked_i   ( locked_i   ),
        .soc_rst_o  ( soc_rst_o  )
    );

    ////////////////////////////////////////////////////////////
    // Host to bus path
    ////////////////////////////////////////////////////////////

    // Downsizer to bus master
    wb_link_if link ();

    // soc_rst_o already covers rst_i
    dwidth_downsizer u_downsizer (
        .main_clk_i ( main_clk_i ),
        .rst_i      ( soc_rst_o  ),
        .host_cyc_i ( host_cyc_i ),
        .host_stb_i ( host_stb_i ),
        .host_we_i  ( host_we_i  ),
        .host_adr_i ( host_adr_i ),
        .host_dat_i ( host_dat_i ),
        .host_sel_i ( host_sel_i ),
        .host_dat_o ( host_dat_o ),
        .host_ack_o ( host_ack_o ),
        .link       ( link       )
    );

    wb_bus_master u_bus_master (
        .main_clk_i ( main_clk_i ),
        .rst_i      ( soc_rst_o  ),
        .link       ( link       ),
        .m_cyc_o    ( m_cyc_o    ),
        .m_stb_o    ( m_stb_o    ),
        .m_we_o     ( m_we_o     ),
        .m_adr_o    ( m_adr_o    ),
        .m_dat_o    ( m_dat_o    ),
        .m_sel_o    ( m_sel_o    ),
        .m_dat_i    ( m_dat_i    ),
        .m_ack_i    ( m_ack_i    )
    );

    // Host side sees nothing until reset has released
    a_quiet_in_reset : assert property (
        @(posedge main_clk_i)
        soc_rst_o |=> !host_ack_o && !m_cyc_o && !m_stb_o
    ) else $error("Activity on host or bus while in reset");

endmodule : sys_master

`default_nettype wire

// File: logic/wb_bus_master.sv
`timescale 1ns/10ps
`default_nettype none

module wb_bus_master
    import sys_master_pkg::*;
(
    input  logic      main_clk_i,
    input  logic      rst_i,

    // Beats from the downsizer
    wb_link_if.slave  link,

    // External 32-bit Wishbone bus
    output logic      m_cyc_o,
    output logic      m_stb_o,
    output logic      m_we_o,
    output addr_t     m_adr_o,
    output bus_data_t m_dat_o,
    output bus_sel_t  m_sel_o,
    input  bus_data_t m_dat_i,
    input  logic      m_ack_i
);

    logic new_req;

    // Request still high during our own ack cycle is the old beat
    assign new_req = link.cyc && link.stb && !link.ack;

    ////////////////////////////////////////////////////////////
    // Bus cycle control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge main_clk_i) begin
        if (rst_i) begin
            m_cyc_o  <= 1'b0;
            m_stb_o  <= 1'b0;
            link.ack <= 1'b0;
        end else begin
            link.ack <= 1'b0;
            if (!m_stb_o) begin
                if (new_req) begin
                    m_cyc_o <= 1'b1;
                    m_stb_o <= 1'b1;
                end
            end else if (m_ack_i) begin
                m_cyc_o  <= 1'b0;   // End of the single transfer
                m_stb_o  <= 1'b0;
                link.ack <= 1'b1;
            end
        end
    end

    // Request payload held for the whole bus cycle
    always_ff @(posedge main_clk_i) begin
        if (!m_stb_o && new_req) begin
            m_we_o  <= link.we;
            m_adr_o <= link.adr;
            m_dat_o <= link.dat_w;
            m_sel_o <= link.sel;
        end
    end

    // Read data returned with the link ack
    always_ff @(posedge main_clk_i) begin
        if (m_stb_o && m_ack_i) link.dat_r <= m_dat_i;
    end

    ////////////////////////////////////////////////////////////
    // Bus protocol checks
    ////////////////////////////////////////////////////////////

    a_stb_in_cyc : assert property (
        @(posedge main_clk_i) disable iff (rst_i)
        $rose(m_stb_o) |-> m_cyc_o
    ) else $error("m_stb_o raised outside a bus cycle");

    // Slave may stall as long as it likes, request stays put
    a_adr_stable : assert property (
        @(posedge main_clk_i) disable iff (rst_i)
        m_stb_o && !m_ack_i |=> m_stb_o && $stable(m_adr_o)
    ) else $error("m_adr_o changed before m_ack_i");

endmodule : wb_bus_master

`default_nettype wire

// File: logic/dwidth_downsizer.sv
`timescale 1ns/10ps
`default_nettype none

module dwidth_downsizer
    import sys_master_pkg::*;
(
    input  logic       main_clk_i,
    input  logic       rst_i,

    // 64-bit host port
    input  logic       host_cyc_i,
    input  logic       host_stb_i,
    input  logic       host_we_i,
    input  addr_t      host_adr_i,
    input  host_data_t host_dat_i,
    input  host_sel_t  host_sel_i,
    output host_data_t host_dat_o,
    output logic       host_ack_o,

    // 32-bit link towards the bus master
    wb_link_if.master  link
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOW,    // Low beat on the link
        ST_GAP,    // Idle cycle between beats
        ST_HIGH,   // High beat on the link
        ST_DONE    // Host ack cycle
    } state_t;

    state_t state_q;

    addr_t base_adr;
    logic  low_used;
    logic  high_used;

    // Host word address, byte offset forced to zero
    assign base_adr = {host_adr_i[ADDR_WIDTH-1:HOST_ALIGN_BITS], {HOST_ALIGN_BITS{1'b0}}};

    // Empty halves are skipped, but an all-zero sel still costs one low beat
    assign high_used = |host_sel_i[HOST_SEL_WIDTH-1:BUS_SEL_WIDTH];
    assign low_used  = |host_sel_i[BUS_SEL_WIDTH-1:0] || !high_used;

    ////////////////////////////////////////////////////////////
    // Beat sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge main_clk_i) begin
        if (rst_i) begin
            state_q    <= ST_IDLE;
            link.cyc   <= 1'b0;
            link.stb   <= 1'b0;
            host_ack_o <= 1'b0;
        end else begin
            host_ack_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (host_cyc_i && host_stb_i) begin
                        link.cyc <= 1'b1;
                        link.stb <= 1'b1;
                        state_q  <= low_used ? ST_LOW : ST_HIGH;
                    end
                end
                ST_LOW: begin
                    if (link.ack) begin
                        link.cyc <= 1'b0;
                        link.stb <= 1'b0;
                        if (high_used) begin
                            state_q <= ST_GAP;
                        end else begin
                            state_q    <= ST_DONE;
                            host_ack_o <= 1'b1;
                        end
                    end
                end
                ST_GAP: begin
                    link.cyc <= 1'b1;
                    link.stb <= 1'b1;
                    state_q  <= ST_HIGH;
                end
                ST_HIGH: begin
                    if (link.ack) begin
                        link.cyc   <= 1'b0;
                        link.stb   <= 1'b0;
                        state_q    <= ST_DONE;
                        host_ack_o <= 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;   // Back to idle after the ack
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Beat payload and read assembly
    ////////////////////////////////////////////////////////////

    always_ff @(posedge main_clk_i) begin
        case (state_q)
            ST_IDLE: begin
                link.we    <= host_we_i;
                host_dat_o <= '0;   // Skipped half reads as zero
                if (low_used) begin
                    link.adr   <= base_adr;
                    link.dat_w <= host_dat_i[BUS_DATA_WIDTH-1:0];
                    link.sel   <= host_sel_i[BUS_SEL_WIDTH-1:0];
                end else begin
                    link.adr   <= addr_t'(base_adr + BUS_SEL_WIDTH);
                    link.dat_w <= host_dat_i[HOST_DATA_WIDTH-1:BUS_DATA_WIDTH];
                    link.sel   <= host_sel_i[HOST_SEL_WIDTH-1:BUS_SEL_WIDTH];
                end
            end
            ST_LOW: begin
                if (link.ack && !link.we) host_dat_o[BUS_DATA_WIDTH-1:0] <= link.dat_r;
            end
            ST_GAP: begin
                link.adr   <= addr_t'(base_adr + BUS_SEL_WIDTH);   // Upper word
                link.dat_w <= host_dat_i[HOST_DATA_WIDTH-1:BUS_DATA_WIDTH];
                link.sel   <= host_sel_i[HOST_SEL_WIDTH-1:BUS_SEL_WIDTH];
            end
            ST_HIGH: begin
                if (link.ack && !link.we) begin
                    host_dat_o[HOST_DATA_WIDTH-1:BUS_DATA_WIDTH] <= link.dat_r;
                end
            end
            default: ;
        endcase
    end

    // Host must hold its request until the beats are through
    a_host_stable : assert property (
        @(posedge main_clk_i) disable iff (rst_i)
        (state_q inside {ST_LOW, ST_GAP, ST_HIGH}) |->
            host_cyc_i && host_stb_i && $stable(host_we_i) && $stable(host_adr_i)
            && $stable(host_dat_i) && $stable(host_sel_i)
    ) else $error("Host request changed during a transfer");

endmodule : dwidth_downsizer

`default_nettype wire

// File: logic/reset_sync.sv
`timescale 1ns/10ps
`default_nettype none

module reset_sync
    import sys_master_pkg::*;
(
    input  logic main_clk_i,
    input  logic rst_i,
    input  logic locked_i,   // Clock generator lock flag
    output logic soc_rst_o   // Active high system reset
);

    ////////////////////////////////////////////////////////////
    // Release chain
    ////////////////////////////////////////////////////////////

    // Fills with ones from bit 0 while the clock is locked
    logic [RESET_SYNC_STAGES-1:0] sync_q;

    always_ff @(posedge main_clk_i) begin
        if (rst_i || !locked_i) begin
            sync_q <= '0;   // Any lock loss restarts the count
        end else begin
            sync_q <= {sync_q[RESET_SYNC_STAGES-2:0], 1'b1};
        end
    end

    // Released once the last stage has filled
    assign soc_rst_o = ~sync_q[RESET_SYNC_STAGES-1];

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Lock loss must reach the system within one edge
    a_lock_loss_resets : assert property (
        @(posedge main_clk_i) disable iff (rst_i)
        !$past(locked_i) |-> soc_rst_o
    ) else $error("soc_rst_o low after locked_i was low");

    // Release never comes sooner than a full chain of locked cycles
    a_release_delay : assert property (
        @(posedge main_clk_i) disable iff (rst_i)
        $fell(soc_rst_o) |-> $past(locked_i, RESET_SYNC_STAGES)
    ) else $error("soc_rst_o released before the chain filled");

endmodule : reset_sync

`default_nettype wire

// File: logic/wb_link_if.sv
`timescale 1ns/10ps
`default_nettype none

// 32-bit Wishbone classic link, single transfers only
interface wb_link_if
    import sys_master_pkg::*;
();

    // Request side
    logic      cyc;
    logic      stb;
    logic      we;
    addr_t     adr;
    bus_data_t dat_w;
    bus_sel_t  sel;

    // Response side
    bus_data_t dat_r;   // Valid with ack on reads
    logic      ack;     // One cycle pulse

    // Downsizer end
    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        output sel,
        input  dat_r,
        input  ack
    );

    // Bus master end
    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        input  sel,
        output dat_r,
        output ack
    );

endinterface : wb_link_if

`default_nettype wire

// File: logic/sys_master_pkg.sv
`default_nettype none

package sys_master_pkg;

    ////////////////////////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////////////////////////

    localparam int unsigned HOST_DATA_WIDTH = 64;  // Host side port
    localparam int unsigned BUS_DATA_WIDTH  = 32;  // System bus
    localparam int unsigned ADDR_WIDTH      = 32;  // Byte address

    // One select bit per data byte
    localparam int unsigned HOST_SEL_WIDTH  = HOST_DATA_WIDTH / 8;
    localparam int unsigned BUS_SEL_WIDTH   = BUS_DATA_WIDTH / 8;

    // Low address bits dropped for a host word
    localparam int unsigned HOST_ALIGN_BITS = $clog2(HOST_SEL_WIDTH);

    // Flops between locked flag and released reset
    localparam int unsigned RESET_SYNC_STAGES = 4;

    ////////////////////////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////////////////////////

    typedef logic [HOST_DATA_WIDTH-1:0] host_data_t;
    typedef logic [BUS_DATA_WIDTH-1:0]  bus_data_t;
    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [HOST_SEL_WIDTH-1:0]  host_sel_t;
    typedef logic [BUS_SEL_WIDTH-1:0]   bus_sel_t;

endpackage : sys_master_pkg

`default_nettype wire
